// ==== hw/div_cfg_pkg.sv ====
`default_nettype none

package div_cfg_pkg;

    // operand and result width
    localparam int data_width = 32;

    // quotient bits retired by each pipeline stage
    localparam int bits_per_stage = 4;

    // pipeline depth, one register rank per stage
    localparam int num_stages = data_width / bits_per_stage;

endpackage

`default_nettype wire

// ==== hw/div_types_pkg.sv ====
`default_nettype none

package div_types_pkg;

    // encoding follows the low two funct3 bits of the riscv divide group
    typedef enum logic [1:0] {
        div_op_div  = 2'b00,  // signed quotient
        div_op_divu = 2'b01,  // unsigned quotient
        div_op_rem  = 2'b10,  // signed remainder
        div_op_remu = 2'b11   // unsigned remainder
    } div_op_e;

    // which half of the division result leaves the unit
    typedef enum logic {
        res_quotient  = 1'b0,
        res_remainder = 1'b1
    } res_sel_e;

endpackage

`default_nettype wire

// ==== hw/div_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface div_stage_if;
    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic                  valid;
    logic [data_width:0]   a;              // partial remainder, two's complement
    logic [data_width-1:0] q;              // dividend shifting out, quotient shifting in
    logic [data_width:0]   m;              // absolute divisor, zero extended
    logic                  neg_q;          // quotient needs negation
    logic                  neg_r;          // remainder needs negation
    logic                  div_zero;       // divisor was zero
    res_sel_e              sel;
    logic [data_width-1:0] orig_dividend;  // raw dividend for the div by zero remainder

    modport src (
        output valid, a, q, m,
        output neg_q, neg_r, div_zero, sel, orig_dividend
    );

    modport dst (
        input valid, a, q, m,
        input neg_q, neg_r, div_zero, sel, orig_dividend
    );

endinterface

`default_nettype wire

// ==== hw/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
    input  logic                              in_valid,
    input  div_types_pkg::div_op_e            op,
    input  logic [div_cfg_pkg::data_width-1:0] dividend,
    input  logic [div_cfg_pkg::data_width-1:0] divisor,
    div_stage_if.src                          launch
);
    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic                  is_signed;
    logic                  sign_a;
    logic                  sign_b;
    logic [data_width-1:0] abs_a;
    logic [data_width-1:0] abs_b;

    assign is_signed = (op == div_op_div) || (op == div_op_rem);

    // operand signs only count for the signed ops
    assign sign_a = is_signed & dividend[data_width-1];
    assign sign_b = is_signed & divisor[data_width-1];

    // most negative value maps onto itself, still correct as unsigned magnitude
    assign abs_a = sign_a ? (~dividend + 1'b1) : dividend;
    assign abs_b = sign_b ? (~divisor + 1'b1) : divisor;

    assign launch.valid = in_valid;
    assign launch.a     = '0;               // partial remainder starts cleared
    assign launch.q     = abs_a;
    assign launch.m     = {1'b0, abs_b};

    assign launch.neg_q    = sign_a ^ sign_b;
    assign launch.neg_r    = sign_a;         // remainder follows the dividend sign
    assign launch.div_zero = (divisor == '0);

    assign launch.sel = ((op == div_op_rem) || (op == div_op_remu)) ? res_remainder
                                                                    : res_quotient;

    assign launch.orig_dividend = dividend;

endmodule

`default_nettype wire

// ==== hw/div_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_stage (
    input  logic     clk,
    input  logic     rst_n,
    div_stage_if.dst up,
    div_stage_if.src dn
);
    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic [data_width:0]   a_nx;
    logic [data_width-1:0] q_nx;

    // bits_per_stage non-restoring steps, unrolled
    always_comb begin
        a_nx = up.a;
        q_nx = up.q;
        for (int i = 0; i < bits_per_stage; i++) begin
            logic a_neg;
            a_neg = a_nx[data_width];
            a_nx  = {a_nx[data_width-1:0], q_nx[data_width-1]};  // shift a,q left as a pair
            if (a_neg) begin
                a_nx = a_nx + up.m;
            end else begin
                a_nx = a_nx - up.m;
            end
            q_nx = {q_nx[data_width-2:0], ~a_nx[data_width]};   // quotient bit from new sign
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dn.valid         <= 1'b0;
            dn.a             <= '0;
            dn.q             <= '0;
            dn.m             <= '0;
            dn.neg_q         <= 1'b0;
            dn.neg_r         <= 1'b0;
            dn.div_zero      <= 1'b0;
            dn.sel           <= res_quotient;
            dn.orig_dividend <= '0;
        end else begin
            dn.valid         <= up.valid;
            dn.a             <= a_nx;
            dn.q             <= q_nx;
            dn.m             <= up.m;          // divisor rides along unchanged
            dn.neg_q         <= up.neg_q;
            dn.neg_r         <= up.neg_r;
            dn.div_zero      <= up.div_zero;
            dn.sel           <= up.sel;
            dn.orig_dividend <= up.orig_dividend;
        end
    end

endmodule

`default_nettype wire

// ==== hw/div_result_fixup.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup (
    div_stage_if.dst                           tail,
    output logic                               out_valid,
    output logic [div_cfg_pkg::data_width-1:0] result
);
    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic [data_width-1:0] rem_abs;
    logic [data_width-1:0] quo_signed;
    logic [data_width-1:0] rem_signed;
    logic [data_width-1:0] quo_final;
    logic [data_width-1:0] rem_final;

    // last non-restoring step may leave a negative remainder
    assign rem_abs = tail.a[data_width] ? (tail.a[data_width-1:0] + tail.m[data_width-1:0])
                                        : tail.a[data_width-1:0];

    assign quo_signed = tail.neg_q ? (~tail.q + 1'b1) : tail.q;
    assign rem_signed = tail.neg_r ? (~rem_abs + 1'b1) : rem_abs;

    // riscv div by zero results
    assign quo_final = tail.div_zero ? '1 : quo_signed;
    assign rem_final = tail.div_zero ? tail.orig_dividend : rem_signed;

    assign out_valid = tail.valid;

    always_comb begin
        if (!tail.valid) begin
            result = '0;
        end else if (tail.sel == res_remainder) begin
            result = rem_final;
        end else begin
            result = quo_final;
        end
    end

endmodule

`default_nettype wire

// ==== hw/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  div_types_pkg::div_op_e             op,
    input  logic [div_cfg_pkg::data_width-1:0] dividend,
    input  logic [div_cfg_pkg::data_width-1:0] divisor,
    output logic                               out_valid,
    output logic [div_cfg_pkg::data_width-1:0] result
);
    import div_cfg_pkg::*;

    // slot 0 is combinational from prep, slot k is stage k-1 registers
    div_stage_if slot [0:num_stages] ();

    div_operand_prep u_prep (
        .in_valid (in_valid),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .launch   (slot[0])
    );

    for (genvar g = 0; g < num_stages; g++) begin : gen_stage
        div_stage u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .up    (slot[g]),
            .dn    (slot[g+1])
        );
    end

    div_result_fixup u_fixup (
        .tail      (slot[num_stages]),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== testbench/div_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_assertions (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               in_valid,
    input logic                               out_valid,
    input logic [div_cfg_pkg::data_width-1:0] result
);
    import div_cfg_pkg::*;

    int unsigned cycles_since_reset;

    // saturates once the pipeline has filled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles_since_reset <= 0;
        end else if (cycles_since_reset < num_stages) begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
    end

    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cycles_since_reset >= num_stages) |-> (out_valid == $past(in_valid, num_stages)))
        else $error("out_valid does not follow in_valid by the pipeline depth");

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (cycles_since_reset < num_stages) |-> !out_valid)
        else $error("out_valid rose before the pipeline could fill after reset");

    a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(result))
        else $error("result holds unknown bits while out_valid is high");

endmodule

bind div_unit div_unit_assertions u_div_unit_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

// ==== testbench/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;
    import div_cfg_pkg::*;
    import div_types_pkg::*;

    localparam int reset_cycles  = 4;
    localparam int random_ops    = 300;
    localparam int drain_timeout = num_stages + 8;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    div_op_e               op;
    logic [data_width-1:0] dividend;
    logic [data_width-1:0] divisor;
    logic                  out_valid;
    logic [data_width-1:0] result;

    logic [data_width-1:0] exp_q[$];  // scoreboard in issue order
    int                    issue_q[$];
    string                 name_q[$];

    int          cycle_cnt;
    int          checked_cnt;
    int          mismatch_cnt;
    int          fail_cnt;
    logic [31:0] rng_state;

    div_unit u_div_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .result    (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // riscv divide semantics with the remainder taking the dividend sign
    function automatic logic [data_width-1:0] ref_result(input div_op_e op_v,
                                                         input logic [data_width-1:0] a,
                                                         input logic [data_width-1:0] b);
        logic signed [data_width-1:0] sa;
        logic signed [data_width-1:0] sb;
        logic [data_width-1:0]        min_neg;
        logic                         overflow;
        logic [data_width-1:0]        res;
        sa       = a;
        sb       = b;
        min_neg  = {1'b1, {(data_width-1){1'b0}}};
        overflow = (a == min_neg) && (b == '1);
        case (op_v)
            div_op_div: begin
                if (b == '0) res = '1;
                else if (overflow) res = min_neg;
                else res = sa / sb;
            end
            div_op_divu: begin
                if (b == '0) res = '1;
                else res = a / b;
            end
            div_op_rem: begin
                if (b == '0) res = a;
                else if (overflow) res = '0;
                else res = sa % sb;
            end
            default: begin
                if (b == '0) res = a;
                else res = a % b;
            end
        endcase
        return res;
    endfunction

    task automatic check_outputs();
        logic [data_width-1:0] exp_v;
        int                    issue_v;
        string                 name_v;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("a result appeared with no operation in flight at cycle %0d", cycle_cnt);
                fail_cnt++;
            end else begin
                exp_v   = exp_q.pop_front();
                issue_v = issue_q.pop_front();
                name_v  = name_q.pop_front();
                checked_cnt++;
                if (result !== exp_v) begin
                    $display("ERR %s expected %h actual %h", name_v, exp_v, result);
                    mismatch_cnt++;
                end
                if (cycle_cnt - issue_v != num_stages) begin
                    $display("ERR %s latency expected %0d actual %0d", name_v, num_stages,
                             cycle_cnt - issue_v);
                    mismatch_cnt++;
                end
            end
        end else if (out_valid !== 1'b0) begin
            $display("out_valid is unknown at cycle %0d", cycle_cnt);
            fail_cnt++;
        end else if (result !== '0) begin
            $display("result is not zero while out_valid is low at cycle %0d", cycle_cnt);
            fail_cnt++;
        end
    endtask

    // sample the outputs on the falling edge and then drive the next slot
    task automatic issue_op(input logic valid_v, input div_op_e op_v,
                            input logic [data_width-1:0] a_v, input logic [data_width-1:0] b_v,
                            input logic [data_width-1:0] exp_v, input string name_v);
        @(negedge clk);
        check_outputs();
        in_valid = valid_v;
        op       = op_v;
        dividend = a_v;
        divisor  = b_v;
        if (valid_v) begin
            exp_q.push_back(exp_v);
            issue_q.push_back(cycle_cnt);
            name_q.push_back(name_v);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            issue_op(1'b0, div_op_div, '0, '0, '0, "idle");
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_timeout) begin
            @(negedge clk);
            check_outputs();
            in_valid = 1'b0;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out after %0d cycles with %0d results still missing",
                     waited, exp_q.size());
            fail_cnt++;
            exp_q.delete();
            issue_q.delete();
            name_q.delete();
        end
    endtask

    task automatic run_vectors();
        int                    fd;
        int                    n;
        int                    line_no;
        string                 line;
        logic [data_width-1:0] op_v;
        logic [data_width-1:0] a_v;
        logic [data_width-1:0] b_v;
        logic [data_width-1:0] exp_v;
        line_no = 0;
        fd = $fopen("testbench/div_unit_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file testbench/div_unit_vectors.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %h", op_v, a_v, b_v, exp_v) != 4) begin
                        $display("vector file line %0d could not be parsed", line_no);
                        fail_cnt++;
                    end else begin
                        if (ref_result(div_op_e'(op_v[1:0]), a_v, b_v) !== exp_v) begin
                            $display("vector file line %0d disagrees with the reference model",
                                     line_no);
                            fail_cnt++;
                        end
                        issue_op(1'b1, div_op_e'(op_v[1:0]), a_v, b_v, exp_v,
                                 $sformatf("vec_line%0d", line_no));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_random();
        logic [31:0]           r;
        logic                  valid_v;
        div_op_e               op_v;
        logic [data_width-1:0] a_v;
        logic [data_width-1:0] b_v;
        for (int i = 0; i < random_ops; i++) begin
            rng_state = lcg_next(rng_state);
            r         = rng_state;
            rng_state = lcg_next(rng_state);
            a_v       = rng_state;
            rng_state = lcg_next(rng_state);
            b_v       = rng_state;
            valid_v   = (r[31:29] != 3'b000);  // about one idle slot in eight
            op_v      = div_op_e'(r[28:27]);
            case (r[26:24])
                3'd0: b_v = '0;
                3'd1: b_v = '1;
                3'd2: b_v = {28'd0, b_v[3:0]};  // small divisors
                3'd3: a_v = {1'b1, 31'd0};
                3'd4: b_v = b_v >> r[20:16];
                default: ;
            endcase
            issue_op(valid_v, op_v, a_v, b_v, ref_result(op_v, a_v, b_v),
                     $sformatf("random%0d", i));
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        op           = div_op_div;
        dividend     = '0;
        divisor      = '0;
        checked_cnt  = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        rng_state    = 32'h9e3f792d;

        repeat (reset_cycles) begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;

        // first operation enters while the pipeline is still filling after reset
        idle_cycles(2);
        run_vectors();
        drain_results();
        idle_cycles(3);
        run_random();
        drain_results();
        idle_cycles(2);

        if (checked_cnt == 0) begin
            $display("no results were checked");
            fail_cnt++;
        end
        $display("checked %0d results, %0d mismatches, %0d other failures",
                 checked_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== div_unit.f ====
hw/div_cfg_pkg.sv
hw/div_types_pkg.sv
hw/div_stage_if.sv
hw/div_operand_prep.sv
hw/div_stage.sv
hw/div_result_fixup.sv
hw/div_unit.sv
testbench/div_unit_assertions.sv
testbench/div_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipelined divide unit

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails on a nonzero exit status or when the log reports failure
run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; \
		exit 1; \
	fi; \
	if grep -q "Result: FAILED" $(LOG); then \
		exit 1; \
	fi; \
	if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation log holds no final result"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/div_unit_vectors.txt ====
# op dividend divisor expected, all in hex
# op: 0 div, 1 divu, 2 rem, 3 remu
0 00000014 00000006 00000003
0 ffffffec 00000006 fffffffd
0 00000014 fffffffa fffffffd
0 ffffffec fffffffa 00000003
2 00000014 00000006 00000002
2 ffffffec 00000006 fffffffe
2 00000014 fffffffa 00000002
2 ffffffec fffffffa fffffffe
1 ffffffec 00000006 2aaaaaa7
3 ffffffec 00000006 00000002
1 00000064 00000007 0000000e
3 00000064 00000007 00000002
0 12345678 00000000 ffffffff
1 87654321 00000000 ffffffff
2 87654321 00000000 87654321
3 12345678 00000000 12345678
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000
1 80000000 ffffffff 00000000
3 80000000 ffffffff 80000000
0 80000000 00000002 c0000000
0 7fffffff 00000001 7fffffff
2 ffffffff 00000002 ffffffff
0 00000005 0000000a 00000000
1 ffffffff ffffffff 00000001
3 ffffffff 00000010 0000000f
0 00000005 80000000 00000000
2 00000005 80000000 00000005
0 80000000 80000000 00000001
1 deadbeef 00000010 0deadbee
